/* build.f */
+incdir+include
rtl/mbesm_pkg.sv
rtl/micro_decode.sv
rtl/micro_execute.sv
rtl/micro_result.sv
rtl/micro_core.sv
dv/micro_core_props.sv
dv/micro_core_tb.sv

/* Bender.yml */
package:
  name: micro_besm_exec

export_include_dirs:
  - include

sources:
  - rtl/mbesm_pkg.sv
  - rtl/micro_decode.sv
  - rtl/micro_execute.sv
  - rtl/micro_result.sv
  - rtl/micro_core.sv
  - target: test
    files:
      - dv/micro_core_props.sv
      - dv/micro_core_tb.sv

/* dv/micro_stimulus.hex */
// Columns: uword (a | alu | pshf dsrc ydst icc | ydev wry mpadr cond), y, shift, cond, stall
// A stall of 1 makes downstream hold its credits back after that result
0ABC_20000000_00640000_00000000 00000000_00000ABC 00000000_00000ABC 0 0
0000_00000000_22000000_00060000 00000000_00000ABC 00000000_0000ABC0 0 0
0AA5_20000000_00E08000_00000000 00000000_00000AA5 00000000_00000552 0 0
0000_20000000_00080000_00000000 00000000_000002A0 00000000_000002A0 0 0
095C_20000000_00610000_00000000 00000000_0000095C 00000000_0000095C 0 1
0000_20000000_24100000_00000000 00000000_0000005C 00000000_00005C00 0 0
0FFF_20000000_3FE20000_00000000 00000000_00000FFF 80000000_00000000 0 0
0000_20000000_05A00000_00000000 00000000_00000800 00000000_00000001 0 0
03A7_20000000_00600000_000B0180 00000000_000003A7 00000000_000003A7 0 0
0F5E_20000000_00600000_000B03C0 00000000_00000F5E 00000000_00000F5E 0 0
0000_00000000_20000000_000A0180 00000000_000000A7 00000000_000000A7 0 0
0000_00000000_01000000_000A03C0 00000000_0000005E 00000000_00000017 0 0
0000_00000000_00000000_000A0000 00000000_00000000 00000000_00000000 0 0
0801_20000000_3A600000_00000000 00000000_00000801 80100000_00000000 0 0
0FFF_20000000_1FE00000_00000000 00000000_00000FFF 00000000_00000000 0 0
0C35_20000000_2F600000_00000000 00000000_00000C35 0000030D_40000000 0 0
0421_20000000_00618000_00000000 00000000_00000421 00000000_00000421 0 0
0000_00000000_00000002_00000002 00000000_00000000 00000000_00000000 1 0
0000_00000000_00000000_00000002 00000000_00000000 00000000_00000000 0 0
0000_00000000_00000002_00000004 00000000_00000000 00000000_00000000 0 1
0000_00000000_00000002_00000006 00000000_00000000 00000000_00000000 1 0
0000_00000000_00000000_00000008 00000000_00000000 00000000_00000000 0 0
0000_00000000_00000000_0000000A 00000000_00000000 00000000_00000000 1 0
0000_00000000_00000002_0000000E 00000000_00000000 00000000_00000000 0 0
0000_00000000_00000002_00000030 00000000_00000000 00000000_00000000 1 0
0000_00000000_00000000_0000003E 00000000_00000000 00000000_00000000 0 0
0000_00000000_00000002_00000000 00000000_00000000 00000000_00000000 1 0
0802_20000000_00618000_00000000 00000000_00000802 00000000_00000802 0 0
0000_00000000_00000002_00000002 00000000_00000000 00000000_00000000 0 0
0000_00000000_00000002_00000004 00000000_00000000 00000000_00000000 1 0
0000_00000000_00000002_0000000A 00000000_00000000 00000000_00000000 1 0
0000_00000000_00000000_0000001A 00000000_00000000 00000000_00000000 1 0
0000_00000000_00000002_0000000C 00000000_00000000 00000000_00000000 0 0
0000_00000000_00000000_00000018 00000000_00000000 00000000_00000000 1 0

/* dv/micro_core_tb.sv */
`timescale 1ns/10ps
`include "mbesm_defs.svh"

module micro_core_tb;
    import mbesm_pkg::*;

    localparam int MAX_TESTS  = 64;
    localparam int COLS       = 5;          // uword, y, shift, cond, stall
    localparam int STALL_CYC  = 16;         // Downstream hold after a flagged result
    localparam int CREDIT_LAT = 2;          // Downstream credit return delay

    logic    clk;
    logic    reset;
    uword_t  i_uword;
    logic    i_valid;
    logic    o_credit;
    logic    i_credit;
    result_t o_res;
    logic    o_valid;

    logic [`MB_UWORD_W-1:0] stim_mem [MAX_TESTS*COLS];
    int   n_tests;
    int   cycle;
    int   limit;
    int   sent;
    int   recv;
    int   in_credits;                       // Upstream credits held
    int   held;                             // Results downstream, not yet credited
    int   stall_until;
    int   n_pass;
    int   n_fail;
    int   due_q[$];                         // Cycle each downstream credit falls due
    logic flow_ok;
    logic done;
    logic timed_out;

    micro_core dut0 (
        .clk      (clk),
        .reset    (reset),
        .i_uword  (i_uword),
        .i_valid  (i_valid),
        .o_credit (o_credit),
        .i_credit (i_credit),
        .o_res    (o_res),
        .o_valid  (o_valid)
    );

    bind micro_core micro_core_props u_props (
        .clk      (clk),
        .reset    (reset),
        .i_valid  (i_valid),
        .o_credit (o_credit),
        .i_credit (i_credit),
        .o_valid  (o_valid)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // -------------------------------------------------
    function automatic int count_tests();
        int n;
        n = 0;                              // Stop at first row without a 0/1 stall flag
        while (n < MAX_TESTS && !$isunknown(stim_mem[n*COLS+4]) && stim_mem[n*COLS+4] <= 1) begin
            n++;
        end
        return n;
    endfunction

    task automatic check_result(input int idx);
        logic [`MB_DATA_W-1:0] exp_y;
        logic [`MB_DATA_W-1:0] exp_shift;
        logic                  exp_cond;
        int                    errs;
        exp_y     = stim_mem[idx*COLS+1][`MB_DATA_W-1:0];
        exp_shift = stim_mem[idx*COLS+2][`MB_DATA_W-1:0];
        exp_cond  = stim_mem[idx*COLS+3][0];
        errs      = 0;
        if (o_res.y !== exp_y) begin
            $display("Mismatch test %0d o_res.y: got %h, expected %h", idx, o_res.y, exp_y);
            errs++;
        end
        if (o_res.shift !== exp_shift) begin
            $display("Mismatch test %0d o_res.shift: got %h, expected %h",
                     idx, o_res.shift, exp_shift);
            errs++;
        end
        if (o_res.cond !== exp_cond) begin
            $display("Mismatch test %0d o_res.cond: got %h, expected %h",
                     idx, o_res.cond, exp_cond);
            errs++;
        end
        if (errs == 0) begin
            n_pass++;
            $display("test %0d: pass", idx);
        end else begin
            n_fail++;
            $display("test %0d: fail", idx);
        end
    endtask

    // -------------------------------------------------
    initial begin
        i_uword     = '0;
        i_valid     = 1'b0;
        i_credit    = 1'b0;
        reset       = 1'b1;
        cycle       = 0;
        sent        = 0;
        recv        = 0;
        in_credits  = `MB_IN_DEPTH;
        held        = 0;
        stall_until = 0;
        n_pass      = 0;
        n_fail      = 0;
        flow_ok     = 1'b1;
        done        = 1'b0;
        timed_out   = 1'b0;
        for (int k = 0; k < MAX_TESTS*COLS; k++) begin
            stim_mem[k] = ~(`MB_UWORD_W'(k));   // Unread rows fail the stall-flag test
        end
        $readmemh("dv/micro_stimulus.hex", stim_mem);
        n_tests = count_tests();
        limit   = 4 * n_tests + 50;
        if (n_tests == 0) begin
            $display("No stimulus lines read from the data file");
            flow_ok = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        while (!done && !timed_out) begin
            @(posedge clk);
            #1;                                 // Outputs settled after the edge
            cycle++;
            if (o_credit) begin
                in_credits++;
            end
            if (o_valid) begin
                if (recv >= n_tests) begin
                    $display("Unexpected result after the last test");
                    flow_ok = 1'b0;
                end else begin
                    check_result(recv);
                    if (stim_mem[recv*COLS+4][0]) begin
                        stall_until = cycle + STALL_CYC;
                    end
                    recv++;
                end
                held++;
                due_q.push_back(cycle + CREDIT_LAT);
                if (held > `MB_OUT_CREDITS) begin
                    $display("Downstream holds %0d results, more than its credits", held);
                    flow_ok = 1'b0;
                end
            end

            // Downstream model returns one due credit per cycle
            i_credit = 1'b0;
            if (cycle >= stall_until && due_q.size() > 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                i_credit = 1'b1;
                held--;
            end

            // Upstream replays the next word while it holds a credit
            i_valid = 1'b0;
            if (sent < n_tests && in_credits > 0) begin
                i_uword = uword_t'(stim_mem[sent*COLS]);
                i_valid = 1'b1;
                in_credits--;
                sent++;
            end

            done      = (recv == n_tests) && (in_credits == `MB_IN_DEPTH) && (held == 0);
            timed_out = (cycle >= limit);
        end

        if (!done) begin
            $display("Timeout after %0d cycles with %0d of %0d results and %0d input credits back",
                     cycle, recv, n_tests, in_credits);
            flow_ok = 1'b0;
        end
        if (flow_ok) begin
            n_pass++;
            $display("test flow_control: pass");
        end else begin
            n_fail++;
            $display("test flow_control: fail");
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
                 n_pass + n_fail, n_pass, n_fail, dut0.u_props.fail_cnt);
        if (n_fail == 0 && dut0.u_props.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* dv/micro_core_props.sv */
`timescale 1ns/10ps
`include "mbesm_defs.svh"

module micro_core_props (
    input logic clk,
    input logic reset,
    input logic i_valid,
    input logic o_credit,
    input logic i_credit,
    input logic o_valid
);
    int unsigned fail_cnt = 0;      // Failed assertion count
    int unsigned accepted;          // Words taken from upstream
    int unsigned returned;          // Credit pulses sent upstream
    int          outstanding;       // Results not yet credited downstream

    always_ff @(posedge clk) begin
        if (reset) begin
            accepted    <= 0;
            returned    <= 0;
            outstanding <= 0;
        end else begin
            accepted    <= accepted + int'(i_valid);
            returned    <= returned + int'(o_credit);
            outstanding <= outstanding + int'(o_valid) - int'(i_credit);
        end
    end

    // -------------------------------------------------
    valid_needs_credit: assert property (@(posedge clk) disable iff (reset)
        o_valid |-> (outstanding < `MB_OUT_CREDITS))
        else begin
            fail_cnt++;
            $error("o_valid raised with no downstream credit held");
        end

    credit_after_word: assert property (@(posedge clk) disable iff (reset)
        o_credit |-> (returned < accepted))
        else begin
            fail_cnt++;
            $error("o_credit returned more credits than words accepted");
        end

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> (!o_valid && !o_credit))
        else begin
            fail_cnt++;
            $error("o_valid or o_credit high after a reset cycle");
        end

endmodule

/* rtl/micro_core.sv */
`timescale 1ns/10ps

module micro_core (
    input  logic               clk,
    input  logic               reset,
    input  mbesm_pkg::uword_t  i_uword,     // Microinstruction in
    input  logic               i_valid,
    output logic               o_credit,    // Credit back to upstream
    input  logic               i_credit,    // Credit from downstream
    output mbesm_pkg::result_t o_res,
    output logic               o_valid
);
    import mbesm_pkg::*;

    uctl_t   ctl;
    logic    ctl_valid;
    result_t res;
    logic    res_valid;
    logic    issue_ok;
    logic    issue_taken;

    // -------------------------------------------------
    micro_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .i_uword       (i_uword),
        .i_valid       (i_valid),
        .i_issue_ok    (issue_ok),
        .o_credit      (o_credit),
        .o_issue_taken (issue_taken),
        .o_ctl         (ctl),
        .o_ctl_valid   (ctl_valid)
    );

    micro_execute u_execute (
        .clk         (clk),
        .reset       (reset),
        .i_ctl       (ctl),
        .i_ctl_valid (ctl_valid),
        .o_res       (res),
        .o_res_valid (res_valid)
    );

    micro_result u_result (
        .clk           (clk),
        .reset         (reset),
        .i_res         (res),
        .i_res_valid   (res_valid),
        .i_credit      (i_credit),
        .i_issue_taken (issue_taken),
        .o_issue_ok    (issue_ok),
        .o_res         (o_res),
        .o_valid       (o_valid)
    );

endmodule

/* rtl/micro_result.sv */
`timescale 1ns/10ps
`include "mbesm_defs.svh"

module micro_result (
    input  logic               clk,
    input  logic               reset,
    input  mbesm_pkg::result_t i_res,
    input  logic               i_res_valid,
    input  logic               i_credit,        // Slot freed downstream
    input  logic               i_issue_taken,   // Decode popped a word
    output logic               o_issue_ok,      // A downstream slot is free
    output mbesm_pkg::result_t o_res,
    output logic               o_valid
);
    import mbesm_pkg::*;

    localparam int CNT_W = $clog2(`MB_OUT_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;               // Unreserved downstream slots
    logic [CNT_W-1:0] cnt_nxt;
    logic             grant;

    assign grant = o_issue_ok && i_issue_taken; // Reserve at pop time

    // -------------------------------------------------
    // Credit counter
    always_comb begin
        cnt_nxt = credit_cnt;
        if (grant && !i_credit) begin
            cnt_nxt = credit_cnt - 1'b1;
        end else if (!grant && i_credit) begin
            cnt_nxt = credit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CNT_W'(`MB_OUT_CREDITS);
            o_issue_ok <= 1'b0;                 // Held low through reset
            o_valid    <= 1'b0;
        end else begin
            credit_cnt <= cnt_nxt;
            o_issue_ok <= (cnt_nxt != '0);      // Follows the new count
            o_valid    <= i_res_valid;
        end
    end

    // Outgoing record
    always_ff @(posedge clk) begin
        if (i_res_valid) begin
            o_res <= i_res;
        end
    end

endmodule

/* rtl/micro_execute.sv */
`timescale 1ns/10ps
`include "mbesm_defs.svh"

module micro_execute (
    input  logic               clk,
    input  logic               reset,
    input  mbesm_pkg::uctl_t   i_ctl,
    input  logic               i_ctl_valid,
    output mbesm_pkg::result_t o_res,
    output logic               o_res_valid
);
    import mbesm_pkg::*;

    logic [4:0]            modgn;                       // Modifier group number
    logic [7:0]            procn;                       // Process number
    logic [31:0]           cnt;                         // Mode register and flags
    logic [9:0]            physpg;                      // Physical page
    logic [31:0]           ureg;                        // Effective address
    logic [7:0]            mpmem [`MB_MPMEM_DEPTH];     // Console exchange memory
    logic [`MB_DATA_W-1:0] d;
    logic [`MB_DATA_W-1:0] y;
    logic [`MB_DATA_W-1:0] shift;
    logic                  condmux;
    logic                  cond;

    // -------------------------------------------------
    // D bus source, zero-extended
    always_comb begin
        d = '0;
        case (i_ctl.dsrc)
            `MB_DSRC_MODGN:  d[9:5]   = modgn;          // Group number field
            `MB_DSRC_PROCN:  d[7:0]   = procn;
            `MB_DSRC_CNT:    d[31:0]  = cnt;
            `MB_DSRC_PHYSPG: d[20:11] = physpg;         // Page field
            `MB_DSRC_IMM:    d[11:0]  = i_ctl.a;        // Immediate from the A field
            default: ;
        endcase
    end

    // Y bus with device reads ahead of the ALU
    always_comb begin
        y = '0;
        if (i_ctl.ydev == `MB_YDEV_UREG && !i_ctl.wry) begin
            y[31:0] = ureg;
        end else if (i_ctl.ydev == `MB_YDEV_MPMEM && !i_ctl.wry) begin
            y[7:0] = mpmem[i_ctl.mpadr];
        end else if (i_ctl.alu) begin
            y = d;                                      // D passes straight onto Y
        end
    end

    // Barrel shifter
    assign shift = i_ctl.pshf[6] ? (y << i_ctl.pshf[5:0]) : (y >> i_ctl.pshf[5:0]);

    // -------------------------------------------------
    // Condition mux over mode register bits
    always_comb begin
        case (i_ctl.cond)
            `MB_COND_YES:    condmux = 1'b1;
            `MB_COND_NORMB:  condmux = cnt[0];
            `MB_COND_RNDB:   condmux = cnt[1];
            `MB_COND_OVRIB:  condmux = cnt[5];
            `MB_COND_BNB:    condmux = cnt[10];
            `MB_COND_OVRFTB: condmux = cnt[11];
            `MB_COND_DRG:    condmux = cnt[12];
            `MB_COND_RCB:    condmux = cnt[28];
            `MB_COND_CB:     condmux = cnt[27];
            `MB_COND_CEMLRG: condmux = cnt[19];
            `MB_COND_INTSTP: condmux = cnt[21];
            default:         condmux = (i_ctl.cond >= `MB_COND_LIMIT);
        endcase
    end

    assign cond = i_ctl.icc ? condmux : ~condmux;       // ICC clear inverts

    // -------------------------------------------------
    // Y destinations and exchange memory writes
    always_ff @(posedge clk) begin
        if (reset) begin
            modgn  <= '0;
            procn  <= '0;
            cnt    <= '0;
            physpg <= '0;
            ureg   <= '0;
            for (int i = 0; i < `MB_MPMEM_DEPTH; i++) begin
                mpmem[i] <= '0;
            end
        end else if (i_ctl_valid) begin
            case (i_ctl.ydst)
                `MB_YDST_MODGN:  modgn  <= y[9:5];
                `MB_YDST_PROCN:  procn  <= y[7:0];
                `MB_YDST_CNT:    cnt    <= y[31:0];
                `MB_YDST_PHYSPG: physpg <= y[20:11];
                `MB_YDST_UREG:   ureg   <= y[31:0];
                default: ;
            endcase
            if (i_ctl.wry && i_ctl.ydev == `MB_YDEV_MPMEM) begin
                mpmem[i_ctl.mpadr] <= y[7:0];           // Byte wide
            end
        end
    end

    // Result record
    always_ff @(posedge clk) begin
        if (i_ctl_valid) begin
            o_res.y     <= y;
            o_res.shift <= shift;
            o_res.cond  <= cond;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= i_ctl_valid;
        end
    end

endmodule

/* rtl/micro_decode.sv */
`timescale 1ns/10ps
`include "mbesm_defs.svh"

module micro_decode (
    input  logic              clk,
    input  logic              reset,
    input  mbesm_pkg::uword_t i_uword,         // Word from upstream
    input  logic              i_valid,         // Spends one upstream credit
    input  logic              i_issue_ok,      // Downstream slot reserved
    output logic              o_credit,        // One pulse per pop
    output logic              o_issue_taken,   // Pop this cycle
    output mbesm_pkg::uctl_t  o_ctl,
    output logic              o_ctl_valid
);
    import mbesm_pkg::*;

    localparam int PTR_W = $clog2(`MB_IN_DEPTH);

    logic [`MB_UWORD_W-1:0] fifo_mem [`MB_IN_DEPTH];   // Sized to the upstream credits
    logic [PTR_W:0]         wr_ptr;                    // Extra bit for wrap
    logic [PTR_W:0]         rd_ptr;
    logic                   empty;
    logic                   pop;
    uword_t                 head;

    assign empty = (wr_ptr == rd_ptr);
    assign pop   = !empty && i_issue_ok;                // Only with a reserved slot
    assign head  = uword_t'(fifo_mem[rd_ptr[PTR_W-1:0]]);
    assign o_issue_taken = pop;

    // -------------------------------------------------
    // FIFO storage and pointers
    always_ff @(posedge clk) begin
        if (i_valid) begin
            fifo_mem[wr_ptr[PTR_W-1:0]] <= i_uword;     // Push at the write pointer
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            o_credit <= pop;                            // One credit per freed slot
        end
    end

    // -------------------------------------------------
    // Field extract into the control register
    always_ff @(posedge clk) begin
        if (pop) begin
            o_ctl.a     <= head.a;
            o_ctl.alu   <= head.alu;
            o_ctl.dsrc  <= head.dsrc;
            o_ctl.ydst  <= head.ydst;
            o_ctl.ydev  <= head.ydev;
            o_ctl.wry   <= head.wry;
            o_ctl.mpadr <= head.ffcnt[3:0];             // MPADR shares FFCNT low bits
            o_ctl.cond  <= head.cond;
            o_ctl.icc   <= head.icc;
            o_ctl.pshf  <= head.pshf;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_ctl_valid <= 1'b0;
        end else begin
            o_ctl_valid <= pop;
        end
    end

endmodule

/* rtl/mbesm_pkg.sv */
`include "mbesm_defs.svh"

package mbesm_pkg;

    // -------------------------------------------------
    // Full microinstruction with machine bits 112:1 at 111:0
    typedef struct packed {
        logic [3:0]  sqi;       // Sequencer opcode
        logic [11:0] a;         // Next address or constant index
        logic [1:0]  map;       // Sequencer D source select
        logic        alu;       // ALU drives Y
        logic [2:0]  alud;      // ALU destination
        logic [2:0]  func;      // ALU function
        logic [2:0]  alus;      // ALU operand source
        logic        h;         // 32-bit mode
        logic [3:0]  rb;        // Reg B address
        logic [3:0]  ra;        // Reg A address
        logic [1:0]  ci;        // Carry control
        logic [3:0]  shmux;     // Status/shift I9-I6
        logic [5:0]  stopc;     // Status/shift I5-I0
        logic        mod;       // Privileged special reg access
        logic [6:0]  pshf;      // Shift parameter
        logic [3:0]  dsrc;      // D bus source
        logic [3:0]  ydst;      // Y bus destination
        logic [1:0]  shf;       // Shifter opcode
        logic [3:0]  arbi;      // Arbiter opcode
        logic        rld;       // Sequencer register load
        logic        letc;      // Pass modify flag to opcode table
        logic [2:0]  cystr;     // Cycle length
        logic        sci;       // Condition to incrementer
        logic        ici;       // Invert incrementer carry
        logic        icc;       // Condition polarity
        logic        ise;       // Interrupt enable
        logic        cem;       // Machine status write
        logic        cen;       // Micro status write
        logic        csm;       // Modifier memory select
        logic        wem;       // Modifier memory write
        logic        ecb;       // Bus port B enable
        logic        wrb;       // Bus port B write
        logic [1:0]  bra;       // Bus port B reg
        logic        eca;       // Bus port A enable
        logic        wra;       // Bus port A write
        logic [1:0]  ara;       // Bus port A reg
        logic [2:0]  ydev;      // Y device
        logic        wry;       // Y device write
        logic [2:0]  ddev;      // D device
        logic        wrd;       // D device write
        logic        iomp;      // Flag decoder or timer select
        logic [4:0]  ffcnt;     // Flag set or reset whose low 4 bits hold MPADR
        logic [4:0]  cond;      // Condition select
        logic        mps;       // Shift parameter source
    } uword_t;

    // Fields the execute stage consumes
    typedef struct packed {
        logic [11:0] a;         // Immediate
        logic        alu;       // Pass D onto Y
        logic [3:0]  dsrc;
        logic [3:0]  ydst;
        logic [2:0]  ydev;
        logic        wry;
        logic [3:0]  mpadr;     // Exchange memory address
        logic [4:0]  cond;
        logic        icc;
        logic [6:0]  pshf;      // Bit 6 picks left shift
    } uctl_t;

    // One record per executed microinstruction
    typedef struct packed {
        logic [`MB_DATA_W-1:0] y;       // Y bus
        logic [`MB_DATA_W-1:0] shift;   // Shifter output
        logic                  cond;    // Tested condition
    } result_t;

endpackage

/* include/mbesm_defs.svh */
`ifndef MBESM_DEFS_SVH
`define MBESM_DEFS_SVH

`define MB_UWORD_W      112     // Microinstruction width
`define MB_DATA_W       64      // Y and D bus width
`define MB_IN_DEPTH     4       // Input FIFO entries, initial upstream credits
`define MB_OUT_CREDITS  4       // Downstream slots we may fill
`define MB_MPMEM_DEPTH  16      // Exchange memory words

// -------------------------------------------------
// D bus sources (DSRC field)
`define MB_DSRC_MODGN   1       // Modifier group number
`define MB_DSRC_PROCN   2       // Process number
`define MB_DSRC_CNT     3       // Mode register
`define MB_DSRC_PHYSPG  4       // Physical page
`define MB_DSRC_IMM     12      // A field as immediate

// Y bus destinations (YDST field)
`define MB_YDST_MODGN   1
`define MB_YDST_PROCN   2
`define MB_YDST_CNT     3
`define MB_YDST_PHYSPG  4
`define MB_YDST_UREG    8       // Effective address register

// Y bus devices (YDEV field)
`define MB_YDEV_UREG    3       // Effective address readback
`define MB_YDEV_MPMEM   5       // Exchange memory with console CPU

// -------------------------------------------------
// Condition codes (COND field)
`define MB_COND_YES     0       // Always true
`define MB_COND_NORMB   1       // Normalization block
`define MB_COND_RNDB    2       // Rounding block
`define MB_COND_OVRIB   3       // Overflow interrupt block
`define MB_COND_BNB     4       // BESM-6 range block
`define MB_COND_OVRFTB  5       // Field overflow check block
`define MB_COND_DRG     6       // Dispatcher mode
`define MB_COND_RCB     8       // Right instruction flag
`define MB_COND_CB      9       // Address modified by reg 16
`define MB_COND_CEMLRG  10      // Reserved mode bit 20
`define MB_COND_INTSTP  13      // Stop on interrupt
`define MB_COND_LIMIT   24      // This and above read as true

`endif
